// ==== build.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/lsu_store_align.sv
src/lsu_load_extract.sv
src/lsu_sram.sv
src/lsu_top.sv
tests/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the load/store unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module lsu_tb -Mdir obj_dir \
	-f build.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vlsu_tb > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$SIM_LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$SIM_LOG"
if grep -qx "ALL TESTS PASSED" "$SIM_LOG"; then
	exit 0
fi
exit 1

// ==== src/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// SRAM window seen by the load/store unit
`define LSU_MEM_BASE    32'h8000_0000
`define LSU_MEM_DWORDS  256

// bus geometry
`define LSU_ADDR_W      32
`define LSU_DATA_W      64
`define LSU_STRB_W      8
`define LSU_MAX_SIZE    3'd3

// AXI response codes
`define LSU_AXI_OKAY    2'b00
`define LSU_AXI_SLVERR  2'b10

`endif

// ==== src/lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
	input  logic        clock,
	input  logic        reset,

	input  logic        req_valid,
	output logic        req_ready,
	input  mem_op_t     req_op,
	output logic        accept,
	output mem_op_t     cur_op,

	output logic        arvalid,
	input  logic        arready,
	input  logic        rvalid,
	output logic        rready,
	input  logic [1:0]  rresp,

	output logic        awvalid,
	input  logic        awready,
	output logic        wvalid,
	input  logic        wready,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,

	input  logic [31:0] load_data,
	output logic        resp_valid,
	output logic [31:0] resp_data,
	output logic        resp_err
);

	lsu_state_t state;
	logic       issued;  // valids for this operation have been raised
	logic       aw_done;
	logic       w_done;
	logic       aw_hs;
	logic       w_hs;

	assign req_ready  = (state == IDLE);
	assign accept     = req_valid & req_ready;
	assign rready     = (state == READ_DATA);
	assign bready     = (state == WRITE_RESP);
	assign resp_valid = (state == DONE);

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= IDLE;
			cur_op    <= LB;
			issued    <= 1'b0;
			arvalid   <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			aw_done   <= 1'b0;
			w_done    <= 1'b0;
			resp_data <= 32'b0;
			resp_err  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						cur_op  <= req_op;
						issued  <= 1'b0;
						aw_done <= 1'b0;
						w_done  <= 1'b0;
						state   <= (req_op inside {SB, SH, SW}) ? WRITE_REQ : READ_ADDR;
					end
				end
				READ_ADDR: begin
					if (!issued) begin
						arvalid <= 1'b1; // the address register has settled by now
						issued  <= 1'b1;
					end else if (arready) begin
						arvalid <= 1'b0;
						state   <= READ_DATA;
					end
				end
				READ_DATA: begin
					if (rvalid) begin
						resp_data <= rresp[1] ? 32'b0 : load_data;
						resp_err  <= rresp[1]; // slverr and decerr both set bit 1
						state     <= DONE;
					end
				end
				WRITE_REQ: begin
					if (!issued) begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						issued  <= 1'b1;
					end else begin
						if (aw_hs) begin
							awvalid <= 1'b0;
							aw_done <= 1'b1;
						end
						if (w_hs) begin
							wvalid <= 1'b0;
							w_done <= 1'b1;
						end
						// the two channels may complete on different edges
						if ((aw_done || aw_hs) && (w_done || w_hs)) begin
							state <= WRITE_RESP;
						end
					end
				end
				WRITE_RESP: begin
					if (bvalid) begin
						resp_data <= 32'b0;
						resp_err  <= bresp[1];
						state     <= DONE;
					end
				end
				DONE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== src/lsu_load_extract.sv ====
`timescale 1ns/1ps

module lsu_load_extract import lsu_pkg::*; (
	input  logic [31:0] addr,
	input  mem_op_t     op,
	input  logic [63:0] rdata,
	output logic [31:0] load_data
);

	logic [31:0] half;
	logic [31:0] shifted;

	// address bit 2 picks the word within the double word
	assign half = addr[2] ? rdata[63:32] : rdata[31:0];

	always_comb begin
		case (addr[1:0])
			2'b00:   shifted = half;
			2'b01:   shifted = {8'b0, half[31:8]};
			2'b10:   shifted = {16'b0, half[31:16]};
			default: shifted = {24'b0, half[31:24]};
		endcase
	end

	always_comb begin
		case (op)
			LB:      load_data = {{24{shifted[7]}}, shifted[7:0]};
			LH:      load_data = {{16{shifted[15]}}, shifted[15:0]};
			LW:      load_data = shifted;
			LBU:     load_data = {24'b0, shifted[7:0]};
			LHU:     load_data = {16'b0, shifted[15:0]};
			default: load_data = 32'b0; // stores return nothing
		endcase
	end

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

	// bit 3 marks a store, bit 2 an unsigned load, bits 1:0 hold log2 of the size
	typedef enum logic [3:0] {
		LB  = 4'b0000,
		LH  = 4'b0001,
		LW  = 4'b0010,
		LBU = 4'b0100,
		LHU = 4'b0101,
		SB  = 4'b1000,
		SH  = 4'b1001,
		SW  = 4'b1010
	} mem_op_t;

	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		READ_ADDR  = 3'd1, // the read address goes out here
		READ_DATA  = 3'd2,
		WRITE_REQ  = 3'd3, // aw and w are issued together here
		WRITE_RESP = 3'd4,
		DONE       = 3'd5
	} lsu_state_t;

endpackage

// ==== src/lsu_sram.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_sram (
	input  logic        clock,
	input  logic        reset,

	input  logic [31:0] araddr,
	input  logic [2:0]  arsize,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	input  logic [31:0] awaddr,
	input  logic [2:0]  awsize,
	input  logic        awvalid,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	localparam int          IDX_W     = $clog2(`LSU_MEM_DWORDS);
	localparam logic [31:0] MEM_BYTES = `LSU_MEM_DWORDS * 8;

	logic [63:0]      mem [0:`LSU_MEM_DWORDS-1];
	logic             ar_hs, aw_hs, w_hs, wr_fire;
	logic             rd_ok, wr_ok;
	logic             aw_got, w_got;
	logic [31:0]      awaddr_q, wr_addr;
	logic [2:0]       awsize_q, wr_size;
	logic [63:0]      wdata_q, wr_data;
	logic [7:0]       wstrb_q, wr_strb;
	logic [IDX_W-1:0] rd_idx, wr_idx;

	// inside the window and no wider than the bus
	function automatic logic addr_ok(input logic [31:0] a, input logic [2:0] sz);
		logic [31:0] off;
		off = a - `LSU_MEM_BASE;
		return (off < MEM_BYTES) && (sz <= `LSU_MAX_SIZE);
	endfunction

	assign arready = ~rvalid;
	assign awready = ~bvalid & ~aw_got;
	assign wready  = ~bvalid & ~w_got;

	assign ar_hs   = arvalid & arready;
	assign aw_hs   = awvalid & awready;
	assign w_hs    = wvalid & wready;
	assign wr_fire = (aw_got | aw_hs) & (w_got | w_hs);

	// a channel that already transferred is served from its holding register
	assign wr_addr = aw_got ? awaddr_q : awaddr;
	assign wr_size = aw_got ? awsize_q : awsize;
	assign wr_data = w_got ? wdata_q : wdata;
	assign wr_strb = w_got ? wstrb_q : wstrb;

	assign rd_ok  = addr_ok(araddr, arsize);
	assign wr_ok  = addr_ok(wr_addr, wr_size);
	assign rd_idx = IDX_W'((araddr - `LSU_MEM_BASE) >> 3);
	assign wr_idx = IDX_W'((wr_addr - `LSU_MEM_BASE) >> 3);

	always_ff @(posedge clock) begin
		if (wr_fire && wr_ok) begin
			for (int i = 0; i < `LSU_STRB_W; i++) begin
				if (wr_strb[i]) begin
					mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) begin
			rdata <= rd_ok ? mem[rd_idx] : 64'b0;
		end
		if (aw_hs) begin
			awaddr_q <= awaddr;
			awsize_q <= awsize;
		end
		if (w_hs) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rvalid <= 1'b0;
			rresp  <= `LSU_AXI_OKAY;
			bvalid <= 1'b0;
			bresp  <= `LSU_AXI_OKAY;
			aw_got <= 1'b0;
			w_got  <= 1'b0;
		end else begin
			if (ar_hs) begin
				rvalid <= 1'b1;
				rresp  <= rd_ok ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end

			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
			end else begin
				if (aw_hs) aw_got <= 1'b1;
				if (w_hs) w_got <= 1'b1;
				if (bvalid && bready) bvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== src/lsu_store_align.sv ====
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        accept,
	input  logic [31:0] base,
	input  logic [31:0] offset,
	input  logic [31:0] wdata_in,
	input  mem_op_t     op,
	output logic [31:0] addr,
	output logic [2:0]  size,
	output logic [63:0] wdata,
	output logic [7:0]  wstrb
);

	logic [31:0] data_q;
	logic [7:0]  byte_mask;

	always_ff @(posedge clock) begin
		if (reset) begin
			addr <= 32'b0;
		end else if (accept) begin
			addr <= base + offset; // held until the operation is over
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			data_q <= wdata_in;
		end
	end

	always_comb begin
		case (op)
			LB, LBU, SB: size = 3'd0;
			LH, LHU, SH: size = 3'd1;
			default:     size = 3'd2;
		endcase
	end

	// loads leave the strobes at zero
	always_comb begin
		case (op)
			SB:      byte_mask = 8'b0000_0001;
			SH:      byte_mask = 8'b0000_0011;
			SW:      byte_mask = 8'b0000_1111;
			default: byte_mask = 8'b0000_0000;
		endcase
	end

	assign wstrb = byte_mask << addr[2:0];
	assign wdata = {32'b0, data_q} << {addr[2:0], 3'b000};

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        req_valid,
	output logic        req_ready,
	input  mem_op_t     req_op,
	input  logic [31:0] req_base,
	input  logic [31:0] req_offset,
	input  logic [31:0] req_wdata,
	output logic        resp_valid,
	output logic [31:0] resp_data,
	output logic        resp_err
);

	logic        accept;
	mem_op_t     cur_op;
	logic [31:0] addr;      // shared by the read and write address channels
	logic [2:0]  size;
	logic [31:0] load_data;

	logic        arvalid, arready;
	logic [63:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid, rready;
	logic        awvalid, awready;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        wvalid, wready;
	logic [1:0]  bresp;
	logic        bvalid, bready;

	lsu_ctrl u_ctrl (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
		.accept(accept), .cur_op(cur_op),
		.arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .rresp(rresp),
		.awvalid(awvalid), .awready(awready),
		.wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.load_data(load_data),
		.resp_valid(resp_valid), .resp_data(resp_data), .resp_err(resp_err)
	);

	lsu_store_align u_store_align (
		.clock(clock), .reset(reset), .accept(accept),
		.base(req_base), .offset(req_offset), .wdata_in(req_wdata), .op(cur_op),
		.addr(addr), .size(size), .wdata(wdata), .wstrb(wstrb)
	);

	lsu_load_extract u_load_extract (
		.addr(addr), .op(cur_op), .rdata(rdata), .load_data(load_data)
	);

	lsu_sram u_sram (
		.clock(clock), .reset(reset),
		.araddr(addr), .arsize(size), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(addr), .awsize(size), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

endmodule

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*; ();

	localparam int          FILL_OPS       = `LSU_MEM_DWORDS * 2;
	localparam int          LANE_OPS       = 42;
	localparam int          EXT_OPS        = 26;
	localparam int          ERR_OPS        = 12;
	localparam int          RAND_OPS       = 400;
	localparam int          TOTAL_OPS      = FILL_OPS + LANE_OPS + EXT_OPS + ERR_OPS + RAND_OPS;
	localparam int          TIMEOUT_CYCLES = TOTAL_OPS * 10 + 100;
	localparam logic [31:0] WIN_BYTES      = `LSU_MEM_DWORDS * 8;
	localparam int          IDX_W          = $clog2(`LSU_MEM_DWORDS * 8);

	logic        clock;
	logic        reset;
	logic        req_valid;
	logic        req_ready;
	mem_op_t     req_op;
	logic [31:0] req_base;
	logic [31:0] req_offset;
	logic [31:0] req_wdata;
	logic        resp_valid;
	logic [31:0] resp_data;
	logic        resp_err;

	logic [7:0]  model_mem [0:`LSU_MEM_DWORDS*8-1]; // byte image of the SRAM window
	logic [31:0] rng_state;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_start = 0;

	lsu_top uut (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
		.req_base(req_base), .req_offset(req_offset), .req_wdata(req_wdata),
		.resp_valid(resp_valid), .resp_data(resp_data), .resp_err(resp_err)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	function automatic logic in_window(input logic [31:0] a);
		logic [31:0] off;
		off = a - `LSU_MEM_BASE;
		return off < WIN_BYTES;
	endfunction

	function automatic logic [IDX_W-1:0] byte_index(input logic [31:0] a);
		logic [31:0] off;
		off = a - `LSU_MEM_BASE;
		return off[IDX_W-1:0];
	endfunction

	function automatic int op_bytes(input mem_op_t op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			default:     return 4;
		endcase
	endfunction

	function automatic logic is_store(input mem_op_t op);
		return (op == SB) || (op == SH) || (op == SW);
	endfunction

	// mixes every address bit so that a misplaced lane shows up
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h3c96_a55a;
	endfunction

	function automatic logic [31:0] outside_addr(input int i);
		case (i)
			0:       return 32'h7fff_fff8;
			1:       return 32'h8000_0800; // first byte past the window
			2:       return 32'h0000_0040;
			default: return 32'hffff_fffc;
		endcase
	endfunction

	function automatic logic [31:0] model_load(input mem_op_t op, input logic [31:0] a);
		logic [31:0] raw;
		raw = 32'b0;
		for (int k = 0; k < op_bytes(op); k++) begin
			raw[k*8 +: 8] = model_mem[byte_index(a + k)];
		end
		case (op)
			LB:      return {{24{raw[7]}}, raw[7:0]};
			LH:      return {{16{raw[15]}}, raw[15:0]};
			default: return raw; // unsigned loads already have zero upper bytes
		endcase
	endfunction

	task automatic model_store(input mem_op_t op, input logic [31:0] a, input logic [31:0] d);
		for (int k = 0; k < op_bytes(op); k++) begin
			model_mem[byte_index(a + k)] = d[k*8 +: 8];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s exp 0x%08h got 0x%08h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s exp 0x%0h got 0x%0h", name, exp, got);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic start_test();
		test_start = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s, %0d errors", tests, name,
			(errors == test_start) ? "pass" : "fail", errors - test_start);
	endtask

	// issues one request and checks its response against the model
	task automatic run_op(input mem_op_t op, input logic [31:0] base, input logic [31:0] offset,
		input logic [31:0] wdata);
		logic [31:0] a;
		logic [31:0] exp_data;
		logic        exp_err;
		logic        got;
		logic [31:0] got_data;
		logic        got_err;
		int          lat;
		a = base + offset;
		exp_err = !in_window(a);
		exp_data = 32'b0;
		if (is_store(op)) begin
			if (!exp_err) begin
				model_store(op, a, wdata);
			end
		end else if (!exp_err) begin
			exp_data = model_load(op, a);
		end
		while (!req_ready) begin
			step();
		end
		req_valid  = 1'b1;
		req_op     = op;
		req_base   = base;
		req_offset = offset;
		req_wdata  = wdata;
		step(); // accepted on this edge
		req_valid = 1'b0;
		check_bit("req_ready", 1'b0, req_ready);
		got = 1'b0;
		got_data = 32'b0;
		got_err = 1'b0;
		lat = 0;
		while (!got && lat < 8) begin
			step();
			lat++;
			if (resp_valid) begin
				got = 1'b1;
				got_data = resp_data;
				got_err = resp_err;
			end
			check_bit("req_ready", 1'b0, req_ready);
		end
		checks++;
		assert (got) else begin
			$display("no response from the DUT for %s at address 0x%08h", op.name(), a);
			errors++;
		end
		if (got) begin
			check_value("resp_valid latency", 32'd4, lat + 1); // the core takes it on the next edge
			check_bit("resp_err", exp_err, got_err);
			if (!is_store(op)) begin
				check_value("resp_data", exp_data, got_data);
			end
		end
		step();
		check_bit("resp_valid", 1'b0, resp_valid);
		check_bit("req_ready", 1'b1, req_ready);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] a;
		logic [31:0] off;
		mem_op_t     op;
		rng_state  = 32'd87799;
		reset      = 1'b1;
		req_valid  = 1'b0;
		req_op     = LB;
		req_base   = 32'b0;
		req_offset = 32'b0;
		req_wdata  = 32'b0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		start_test();
		check_bit("req_ready", 1'b1, req_ready);
		check_bit("resp_valid", 1'b0, resp_valid);
		end_test("reset state");

		start_test();
		for (int i = 0; i < FILL_OPS; i++) begin
			a = `LSU_MEM_BASE + i * 4;
			run_op(SW, a, 32'd0, fill_word(a));
		end
		end_test("memory fill");

		start_test();
		next_rand(r);
		d = `LSU_MEM_BASE + {21'b0, r[10:3], 3'b000};
		for (int b = 0; b < 8; b++) begin
			next_rand(r);
			run_op(SB, d, b, r);
			run_op(LW, d, 32'd0, 32'd0);
			run_op(LW, d, 32'd4, 32'd0);
		end
		for (int b = 0; b < 8; b += 2) begin
			next_rand(r);
			run_op(SH, d, b, r);
			run_op(LW, d, 32'd0, 32'd0);
			run_op(LW, d, 32'd4, 32'd0);
		end
		for (int b = 0; b < 8; b += 4) begin
			next_rand(r);
			run_op(SW, d, b, r);
			run_op(LW, d, 32'd0, 32'd0);
			run_op(LW, d, 32'd4, 32'd0);
		end
		end_test("store lanes");

		start_test();
		d = `LSU_MEM_BASE + 32'h100;
		run_op(SW, d, 32'd0, 32'h80ff_7f01); // both signs in each half
		run_op(SW, d, 32'd4, 32'h01fe_8070);
		for (int b = 0; b < 8; b++) begin
			run_op(LB, d, b, 32'd0);
			run_op(LBU, d, b, 32'd0);
		end
		for (int b = 0; b < 8; b += 2) begin
			run_op(LH, d, b, 32'd0);
			run_op(LHU, d, b, 32'd0);
		end
		end_test("load extension");

		start_test();
		for (int i = 0; i < 4; i++) begin
			a = outside_addr(i);
			next_rand(r);
			run_op(SW, a, 32'd0, r);
			run_op(LW, a, 32'd0, 32'd0);
			run_op(LW, `LSU_MEM_BASE + (a & 32'h7fc), 32'd0, 32'd0); // index the SRAM would alias to
		end
		end_test("window errors");

		start_test();
		for (int n = 0; n < RAND_OPS; n++) begin
			next_rand(r);
			case (r[2:0])
				3'd0: op = LB;
				3'd1: op = LH;
				3'd2: op = LW;
				3'd3: op = LBU;
				3'd4: op = LHU;
				3'd5: op = SB;
				3'd6: op = SH;
				3'd7: op = SW;
			endcase
			next_rand(r);
			if (r[31:29] == 3'b000) begin
				next_rand(a);
				if (in_window(a)) begin
					a = a ^ 32'h4000_0000;
				end
			end else begin
				a = `LSU_MEM_BASE + {21'b0, r[10:0]};
			end
			if (op_bytes(op) == 2) begin
				a[0] = 1'b0;
			end else if (op_bytes(op) == 4) begin
				a[1:0] = 2'b00;
			end
			next_rand(r);
			off = {{20{r[11]}}, r[11:0]}; // offsets span the signed 12-bit immediate range
			next_rand(d);
			run_op(op, a - off, off, d);
		end
		end_test("random mix");

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
